//--- Makefile
# Verilator build and run of the waveform player testbench

VERILATOR ?= verilator
TOP       ?= waveform_player_tb
FILE_LIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
HEADERS := $(wildcard dv/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	@output="$$($(SIM))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/host_tasks.svh
/*
 * waveform player testbench tasks
 * host bus handshake, compare tasks and the directed tests
 */

// ------------------------------------------------
// compare tasks
task check_word(input string name, input logic [waveform_pkg::DATA_WIDTH-1:0] got,
		input logic [waveform_pkg::DATA_WIDTH-1:0] expected);
	checks_run++;
	if (got !== expected) begin
		error_count++;
		$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
	end
endtask

task check_sample(input string name, input logic [waveform_pkg::SAMPLE_WIDTH-1:0] got,
		input logic [waveform_pkg::SAMPLE_WIDTH-1:0] expected);
	checks_run++;
	if (got !== expected) begin
		error_count++;
		$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
	end
endtask

task check_count(input string name, input logic [host_bus_pkg::ERROR_COUNT_WIDTH-1:0] got,
		input logic [host_bus_pkg::ERROR_COUNT_WIDTH-1:0] expected);
	checks_run++;
	if (got !== expected) begin
		error_count++;
		$display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, expected);
	end
endtask

task report_failure(input string text);
	error_count++;
	$display("%s, at %0t", text, $time);
endtask

task begin_test(input string name);
	current_test = name;
	test_start_errors = error_count;
endtask

task end_test();
	test_count++;
	$display("test %s done, %0d errors", current_test, error_count - test_start_errors);
endtask

// ------------------------------------------------
// four-phase host handshake paced by ack_valid
task wait_ack(input logic level);
	int cycles;
	cycles = 0;
	while (!timed_out && ack_valid !== level) begin
		@(negedge clock);
		cycles++;
		if (cycles > 64) begin
			timed_out = 1'b1;
			$display("timeout waiting for ack_valid to go %0d in %s", level, current_test);
		end
	end
endtask

task bus_cycle(input logic is_read, input logic is_data,
		input logic [host_bus_pkg::BUS_WIDTH-1:0] data,
		output logic [host_bus_pkg::BUS_WIDTH-1:0] returned);
	read = is_read; // held until the next transaction
	register_select = is_data;
	bus_in = data;
	enable = 1'b1;
	wait_ack(1'b1);
	returned = bus_out;
	if (!timed_out && bus_out_enable !== is_read) begin
		report_failure("bus_out_enable does not follow read");
	end
	enable = 1'b0;
	wait_ack(1'b0);
endtask

task set_address(input logic [waveform_pkg::WORD_ADDR_WIDTH-1:0] address);
	logic [host_bus_pkg::BUS_WIDTH-1:0] padded;
	logic [host_bus_pkg::BUS_WIDTH-1:0] unused;
	padded = '0;
	padded[waveform_pkg::WORD_ADDR_WIDTH-1:0] = address;
	bus_cycle(1'b0, 1'b0, padded, unused);
	model_address = address;
endtask

task write_word(input logic [waveform_pkg::DATA_WIDTH-1:0] word);
	logic [host_bus_pkg::BUS_WIDTH-1:0] unused;
	bus_cycle(1'b0, 1'b1, word[waveform_pkg::DATA_WIDTH-1 -: host_bus_pkg::BUS_WIDTH], unused);
	bus_cycle(1'b0, 1'b1, word[host_bus_pkg::BUS_WIDTH-1:0], unused);
	shadow[model_address] = word;
	model_address++;
endtask

task read_word(output logic [waveform_pkg::DATA_WIDTH-1:0] word);
	logic [host_bus_pkg::BUS_WIDTH-1:0] high_half;
	logic [host_bus_pkg::BUS_WIDTH-1:0] low_half;
	bus_cycle(1'b1, 1'b0, '0, high_half); // high half comes first
	bus_cycle(1'b1, 1'b0, '0, low_half);
	word = {high_half, low_half};
	model_address++;
endtask

// counts falling edges up to the next sync_out
task wait_sync(output int cycles);
	cycles = 0;
	do begin
		@(negedge clock);
		sync_in = 1'b0; // pulses last one cycle
		cycles++;
	end while (!timed_out && sync_out !== 1'b1 && cycles <= waveform_pkg::PLAY_LENGTH + 16);
	if (!timed_out && sync_out !== 1'b1) begin
		timed_out = 1'b1;
		$display("timeout waiting for sync_out in %s", current_test);
	end
endtask

// ------------------------------------------------
// directed tests
task test_reset_state();
	begin_test("reset_state");
	check_count("read_errors", read_errors, '0);
	check_count("write_errors", write_errors, '0);
	check_count("address_errors", address_errors, '0);
	if (ack_valid !== 1'b0 || bus_out_enable !== 1'b0 || sync_out !== 1'b0) begin
		report_failure("ack_valid, bus_out_enable or sync_out not low after reset");
	end
	end_test();
endtask

task test_write_readback();
	logic [waveform_pkg::DATA_WIDTH-1:0] word;
	logic [waveform_pkg::WORD_ADDR_WIDTH-1:0] address;
	begin_test("write_readback");
	set_address(16);
	repeat (8) write_word($urandom());
	set_address(16);
	address = 16;
	repeat (8) begin
		read_word(word);
		check_word($sformatf("word %0d", address), word, shadow[address]);
		address++;
	end
	end_test();
endtask

task test_address_reload();
	logic [waveform_pkg::DATA_WIDTH-1:0] word;
	begin_test("address_reload");
	set_address(21);
	read_word(word);
	check_word("word 21", word, shadow[21]);
	set_address(18); // back below the autoincremented address
	read_word(word);
	check_word("word 18", word, shadow[18]);
	end_test();
endtask

task test_interrupted_write();
	logic [host_bus_pkg::BUS_WIDTH-1:0] half;
	logic [waveform_pkg::DATA_WIDTH-1:0] word;
	logic [waveform_pkg::DATA_WIDTH-1:0] expected;
	begin_test("interrupted_write");
	set_address(40);
	bus_cycle(1'b0, 1'b1, '1, half);
	bus_cycle(1'b1, 1'b0, '0, half); // read drops the half-built word
	expected_write_errors++;
	check_count("write_errors", write_errors, expected_write_errors);
	bus_cycle(1'b1, 1'b0, '0, half);
	expected = $urandom();
	set_address(40);
	write_word(expected);
	set_address(40);
	read_word(word);
	check_word("word 40", word, expected);
	check_count("write_errors", write_errors, expected_write_errors);
	check_count("read_errors", read_errors, expected_read_errors);
	end_test();
endtask

task test_interrupted_read();
	logic [host_bus_pkg::BUS_WIDTH-1:0] half;
	begin_test("interrupted_read");
	set_address(16);
	bus_cycle(1'b1, 1'b0, '0, half);
	set_address(16); // address transaction cancels the partial read
	expected_read_errors++;
	check_count("read_errors", read_errors, expected_read_errors);
	check_count("write_errors", write_errors, expected_write_errors);
	check_count("address_errors", address_errors, '0);
	end_test();
endtask

task test_playback_bytes();
	logic [waveform_pkg::BYTE_ADDR_WIDTH-1:0] byte_index;
	logic [waveform_pkg::DATA_WIDTH-1:0] lane_word;
	int cycles;
	begin_test("playback_bytes");
	set_address(0);
	repeat (4) write_word($urandom());
	wait_sync(cycles); // just after a restart and far from the next wrap
	sync_in = 1'b1;
	wait_sync(cycles);
	// one edge samples sync_in and two more reach the first byte
	if (!timed_out && cycles != 3) begin
		report_failure($sformatf("sync_out came %0d cycles after sync_in, not 2", cycles - 1));
	end
	byte_index = '0;
	repeat (16) begin
		lane_word = shadow[byte_index[waveform_pkg::BYTE_ADDR_WIDTH-1:waveform_pkg::LANE_WIDTH]]
			>> (waveform_pkg::SAMPLE_WIDTH * int'(byte_index[waveform_pkg::LANE_WIDTH-1:0]));
		check_sample($sformatf("sample %0d", byte_index), sample,
			lane_word[waveform_pkg::SAMPLE_WIDTH-1:0]);
		if (sync_out !== (byte_index == 0)) begin
			report_failure($sformatf("sync_out wrong at byte %0d", byte_index));
		end
		byte_index++;
		@(negedge clock);
	end
	end_test();
endtask

task test_playback_wrap();
	int cycles;
	begin_test("playback_wrap");
	wait_sync(cycles);
	wait_sync(cycles);
	if (!timed_out && cycles != waveform_pkg::PLAY_LENGTH) begin
		report_failure($sformatf("sync_out repeated after %0d cycles, not %0d",
			cycles, waveform_pkg::PLAY_LENGTH));
	end
	check_sample("sample 0 after wrap", sample, shadow[0][waveform_pkg::SAMPLE_WIDTH-1:0]);
	end_test();
endtask

//--- dv/waveform_player_tb.sv
/*
 * waveform player testbench
 * clock, reset, DUT instance and the directed test sequence
 */

`default_nettype none

module waveform_player_tb;

	logic clock;
	logic reset125;
	logic enable;
	logic read;
	logic register_select;
	logic [host_bus_pkg::BUS_WIDTH-1:0] bus_in;
	logic sync_in;
	logic ack_valid;
	logic [host_bus_pkg::BUS_WIDTH-1:0] bus_out;
	logic bus_out_enable;
	logic [host_bus_pkg::ERROR_COUNT_WIDTH-1:0] read_errors;
	logic [host_bus_pkg::ERROR_COUNT_WIDTH-1:0] write_errors;
	logic [host_bus_pkg::ERROR_COUNT_WIDTH-1:0] address_errors;
	logic [waveform_pkg::SAMPLE_WIDTH-1:0] sample;
	logic sync_out;

	// ------------------------------------------------
	// reference model and bookkeeping
	logic [waveform_pkg::DATA_WIDTH-1:0] shadow [waveform_pkg::WORD_COUNT];
	logic [waveform_pkg::WORD_ADDR_WIDTH-1:0] model_address; // follows autoincrement
	logic [host_bus_pkg::ERROR_COUNT_WIDTH-1:0] expected_read_errors;
	logic [host_bus_pkg::ERROR_COUNT_WIDTH-1:0] expected_write_errors;
	logic [31:0] seed_result;
	logic timed_out;
	string current_test;
	int error_count;
	int checks_run;
	int test_count;
	int test_start_errors;

	waveform_player waveform_player_inst (
		.clock(clock), .reset125(reset125),
		.enable(enable), .read(read), .register_select(register_select), .bus_in(bus_in),
		.sync_in(sync_in), .ack_valid(ack_valid),
		.bus_out(bus_out), .bus_out_enable(bus_out_enable),
		.read_errors(read_errors), .write_errors(write_errors),
		.address_errors(address_errors), .sample(sample), .sync_out(sync_out)
	);

	always #4 clock = ~clock; // period 8

	initial begin
		clock = 1'b0;
		reset125 = 1'b1;
		enable = 1'b0;
		read = 1'b0;
		register_select = 1'b0;
		bus_in = '0;
		sync_in = 1'b0;
		model_address = '0;
		expected_read_errors = '0;
		expected_write_errors = '0;
		timed_out = 1'b0;
		error_count = 0;
		checks_run = 0;
		test_count = 0;
		seed_result = $urandom(32'h2309990c);
		repeat (16) @(negedge clock);
		reset125 = 1'b0;
		@(negedge clock);

		test_reset_state();
		if (!timed_out) test_write_readback();
		if (!timed_out) test_address_reload();
		if (!timed_out) test_interrupted_write();
		if (!timed_out) test_interrupted_read();
		if (!timed_out) test_playback_bytes();
		if (!timed_out) test_playback_wrap();

		$display("tests %0d, checks %0d, errors %0d, timeout %0d",
			test_count, checks_run, error_count, timed_out);
		if (error_count == 0 && !timed_out) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	`include "host_tasks.svh"

endmodule

`default_nettype wire

//--- logic/host_bus_pkg.sv
/*
 * host bus definitions
 * halfword width, word assembly, strobe filtering and transaction kinds
 */

`default_nettype none

package host_bus_pkg;

	// ------------------------------------------------
	// bus geometry
	localparam int BUS_WIDTH = 16;
	localparam int HALVES_PER_WORD = 2; // most significant halfword first
	localparam int HALF_INDEX_WIDTH = $clog2(HALVES_PER_WORD);
	localparam logic [HALF_INDEX_WIDTH-1:0] LAST_HALF = HALF_INDEX_WIDTH'(HALVES_PER_WORD - 1);

	// ------------------------------------------------
	// strobe conditioning
	localparam int FILTER_DEPTH = 3; // sync stages before a strobe is judged
	localparam int STROBE_COUNT = 3; // enable, read, register_select

	localparam int ERROR_COUNT_WIDTH = 16;

	typedef enum logic [1:0] {
		TXN_IDLE,
		TXN_ADDRESS, // read low, register_select low
		TXN_WRITE,   // read low, register_select high
		TXN_READ     // read high
	} transaction_kind_t;

endpackage

`default_nettype wire

//--- logic/host_bus_slave.sv
/*
 * host bus slave
 * decodes address, write and read transactions, assembles 32-bit words from
 * halfwords, autoincrements the word address and counts interrupted transactions
 */

`default_nettype none

module host_bus_slave (
	input  logic clock,
	input  logic reset125,
	input  logic enable_f,
	input  logic read_f,
	input  logic select_f,
	input  logic [host_bus_pkg::BUS_WIDTH-1:0] bus_f,
	input  logic [waveform_pkg::DATA_WIDTH-1:0] read_word,
	output logic ack_valid,
	output logic [host_bus_pkg::BUS_WIDTH-1:0] bus_out,
	output logic bus_out_enable,
	output logic [waveform_pkg::WORD_ADDR_WIDTH-1:0] word_address,
	output logic write_strobe,
	output logic [waveform_pkg::DATA_WIDTH-1:0] write_data,
	output logic [host_bus_pkg::ERROR_COUNT_WIDTH-1:0] read_errors,
	output logic [host_bus_pkg::ERROR_COUNT_WIDTH-1:0] write_errors,
	output logic [host_bus_pkg::ERROR_COUNT_WIDTH-1:0] address_errors
);

	host_bus_pkg::transaction_kind_t kind;        // latched on rising enable
	host_bus_pkg::transaction_kind_t strobe_kind; // what the strobes say now
	logic [host_bus_pkg::HALF_INDEX_WIDTH-1:0] write_index;
	logic [host_bus_pkg::HALF_INDEX_WIDTH-1:0] read_index;
	logic enable_d;
	logic enable_rise;
	logic enable_fall;
	logic increment_pending;

	assign enable_rise = enable_f & ~enable_d;
	assign enable_fall = ~enable_f & enable_d;

	always_comb begin
		if (read_f) begin
			strobe_kind = host_bus_pkg::TXN_READ;
		end else if (select_f) begin
			strobe_kind = host_bus_pkg::TXN_WRITE;
		end else begin
			strobe_kind = host_bus_pkg::TXN_ADDRESS;
		end
	end

	// ------------------------------------------------
	// transaction control
	always_ff @(posedge clock) begin
		if (reset125) begin
			kind <= host_bus_pkg::TXN_IDLE;
			write_index <= '0;
			read_index <= '0;
			enable_d <= 1'b0;
			ack_valid <= 1'b0;
			bus_out_enable <= 1'b0;
			write_strobe <= 1'b0;
			increment_pending <= 1'b0;
			word_address <= '0;
			read_errors <= '0;
			write_errors <= '0;
			address_errors <= '0;
		end else begin
			enable_d <= enable_f;
			ack_valid <= enable_f; // one cycle behind the filtered enable
			bus_out_enable <= read_f;
			write_strobe <= 1'b0;
			increment_pending <= 1'b0;
			if (increment_pending) begin
				word_address <= word_address + 1'b1;
			end
			if (enable_rise) begin
				kind <= strobe_kind;
				// another kind arriving drops a half-built word
				if (write_index != '0 && strobe_kind != host_bus_pkg::TXN_WRITE) begin
					write_errors <= write_errors + 1'b1;
					write_index <= '0;
				end
				if (read_index != '0 && strobe_kind != host_bus_pkg::TXN_READ) begin
					read_errors <= read_errors + 1'b1;
					read_index <= '0;
				end
			end
			if (enable_fall) begin
				kind <= host_bus_pkg::TXN_IDLE;
				if (strobe_kind != kind) begin
					// strobes changed under a held enable, abandon it
					case (kind)
						host_bus_pkg::TXN_ADDRESS: begin
							address_errors <= address_errors + 1'b1;
						end
						host_bus_pkg::TXN_WRITE: begin
							write_errors <= write_errors + 1'b1;
							write_index <= '0;
						end
						host_bus_pkg::TXN_READ: begin
							read_errors <= read_errors + 1'b1;
							read_index <= '0;
						end
						default: begin
						end
					endcase
				end else begin
					case (kind)
						host_bus_pkg::TXN_ADDRESS: begin
							word_address <= bus_f[waveform_pkg::WORD_ADDR_WIDTH-1:0];
						end
						host_bus_pkg::TXN_WRITE: begin
							if (write_index == host_bus_pkg::LAST_HALF) begin
								write_index <= '0;
								write_strobe <= 1'b1;
								increment_pending <= 1'b1;
							end else begin
								write_index <= write_index + 1'b1;
							end
						end
						host_bus_pkg::TXN_READ: begin
							if (read_index == host_bus_pkg::LAST_HALF) begin
								read_index <= '0;
								increment_pending <= 1'b1;
							end else begin
								read_index <= read_index + 1'b1;
							end
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

	// ------------------------------------------------
	// data path, halves shift in msb first
	always_ff @(posedge clock) begin
		if (enable_rise && strobe_kind == host_bus_pkg::TXN_READ) begin
			bus_out <= read_word[waveform_pkg::DATA_WIDTH - 1
				- int'(read_index) * host_bus_pkg::BUS_WIDTH -: host_bus_pkg::BUS_WIDTH];
		end
		if (enable_rise && strobe_kind == host_bus_pkg::TXN_WRITE) begin
			write_data <= {write_data[waveform_pkg::DATA_WIDTH-host_bus_pkg::BUS_WIDTH-1:0],
				bus_f};
		end
	end

endmodule

`default_nettype wire

//--- logic/playback_sequencer.sv
/*
 * playback sequencer
 * steps the byte address once per clock, wraps at the loop length,
 * restarts on sync_in and flags each restart on sync_out
 */

`default_nettype none

module playback_sequencer (
	input  logic clock,
	input  logic reset125,
	input  logic sync_in,
	output logic [waveform_pkg::BYTE_ADDR_WIDTH-1:0] byte_address,
	output logic sync_out
);

	logic sync_seen;
	logic restart; // high while byte_address is 0 after a restart

	always_ff @(posedge clock) begin
		if (reset125) begin
			sync_seen <= 1'b0;
			restart <= 1'b0;
			sync_out <= 1'b0;
			byte_address <= '0;
		end else begin
			sync_seen <= sync_in; // registered external sync
			restart <= 1'b0;
			if (sync_seen || byte_address == waveform_pkg::LAST_BYTE) begin
				byte_address <= '0;
				restart <= 1'b1;
			end else begin
				byte_address <= byte_address + 1'b1;
			end
			sync_out <= restart; // matches memory read latency
		end
	end

endmodule

`default_nettype wire

//--- logic/strobe_filter.sv
/*
 * host strobe conditioning
 * synchronizes enable, read and register_select, rejects single-sample glitches,
 * and delays the bus data so it lines up with the filtered strobes
 */

`default_nettype none

module strobe_filter (
	input  logic clock,
	input  logic reset125,
	input  logic enable,
	input  logic read,
	input  logic register_select,
	input  logic [host_bus_pkg::BUS_WIDTH-1:0] bus_in,
	output logic enable_f,
	output logic read_f,
	output logic select_f,
	output logic [host_bus_pkg::BUS_WIDTH-1:0] bus_f
);

	logic [host_bus_pkg::FILTER_DEPTH-1:0][host_bus_pkg::STROBE_COUNT-1:0] strobe_sync;
	logic [host_bus_pkg::STROBE_COUNT-1:0] strobe_agree;
	logic [host_bus_pkg::STROBE_COUNT-1:0] strobe_filtered;
	logic [host_bus_pkg::FILTER_DEPTH:0][host_bus_pkg::BUS_WIDTH-1:0] bus_delay;

	// a bit only moves when the last two stages agree
	assign strobe_agree = ~(strobe_sync[host_bus_pkg::FILTER_DEPTH-1]
		^ strobe_sync[host_bus_pkg::FILTER_DEPTH-2]);

	always_ff @(posedge clock) begin
		if (reset125) begin
			strobe_sync <= '0;
			strobe_filtered <= '0;
		end else begin
			strobe_sync <= {strobe_sync[host_bus_pkg::FILTER_DEPTH-2:0],
				{register_select, read, enable}};
			strobe_filtered <= (strobe_filtered & ~strobe_agree)
				| (strobe_sync[host_bus_pkg::FILTER_DEPTH-1] & strobe_agree);
		end
	end

	// ------------------------------------------------
	// bus data, one stage per strobe stage plus the filter
	always_ff @(posedge clock) begin
		bus_delay <= {bus_delay[host_bus_pkg::FILTER_DEPTH-1:0], bus_in};
	end

	assign {select_f, read_f, enable_f} = strobe_filtered;
	assign bus_f = bus_delay[host_bus_pkg::FILTER_DEPTH];

endmodule

`default_nettype wire

//--- logic/waveform_memory.sv
/*
 * dual-port waveform storage
 * 32-bit read/write port for the host, 8-bit read port for playback
 */

`default_nettype none

module waveform_memory (
	input  logic clock,
	input  logic [waveform_pkg::WORD_ADDR_WIDTH-1:0] word_address,
	input  logic write_strobe,
	input  logic [waveform_pkg::DATA_WIDTH-1:0] write_data,
	output logic [waveform_pkg::DATA_WIDTH-1:0] read_word,
	input  logic [waveform_pkg::BYTE_ADDR_WIDTH-1:0] byte_address,
	output logic [waveform_pkg::SAMPLE_WIDTH-1:0] sample
);

	logic [waveform_pkg::DATA_WIDTH-1:0] storage [waveform_pkg::WORD_COUNT];
	logic [waveform_pkg::DATA_WIDTH-1:0] sample_word;
	logic [waveform_pkg::LANE_WIDTH-1:0] sample_lane;

	// ------------------------------------------------
	// port a, word wide
	always_ff @(posedge clock) begin
		if (write_strobe) begin
			storage[word_address] <= write_data;
		end
		read_word <= storage[word_address];
	end

	// ------------------------------------------------
	// port b, gearbox down to bytes
	always_ff @(posedge clock) begin
		sample_word <= storage[byte_address[waveform_pkg::BYTE_ADDR_WIDTH-1:
			waveform_pkg::LANE_WIDTH]];
		sample_lane <= byte_address[waveform_pkg::LANE_WIDTH-1:0];
	end

	// lane 0 is the least significant byte
	assign sample = sample_word[int'(sample_lane) * waveform_pkg::SAMPLE_WIDTH +:
		waveform_pkg::SAMPLE_WIDTH];

endmodule

`default_nettype wire

//--- logic/waveform_pkg.sv
/*
 * waveform memory definitions
 * word and byte geometry of the storage and the playback loop length
 */

`default_nettype none

package waveform_pkg;

	localparam int WORD_ADDR_WIDTH = 10;
	localparam int WORD_COUNT = 2 ** WORD_ADDR_WIDTH; // 1024 words
	localparam int DATA_WIDTH = 32;
	localparam int SAMPLE_WIDTH = 8;

	// byte lanes per word, lane k is bits 8k+7:8k
	localparam int LANE_WIDTH = $clog2(DATA_WIDTH / SAMPLE_WIDTH);
	localparam int BYTE_ADDR_WIDTH = WORD_ADDR_WIDTH + LANE_WIDTH; // 12

	// playback loop
	localparam int PLAY_LENGTH = 4096;
	localparam logic [BYTE_ADDR_WIDTH-1:0] LAST_BYTE = BYTE_ADDR_WIDTH'(PLAY_LENGTH - 1);

endpackage

`default_nettype wire

//--- logic/waveform_player.sv
/*
 * waveform player top level
 * host-filled dual-port memory streamed out one byte per clock
 */

`default_nettype none

module waveform_player (
	input  logic clock,
	input  logic reset125,
	input  logic enable,
	input  logic read,            // 0 write, 1 read
	input  logic register_select, // 0 address, 1 data
	input  logic [host_bus_pkg::BUS_WIDTH-1:0] bus_in,
	input  logic sync_in,
	output logic ack_valid,
	output logic [host_bus_pkg::BUS_WIDTH-1:0] bus_out,
	output logic bus_out_enable,
	output logic [host_bus_pkg::ERROR_COUNT_WIDTH-1:0] read_errors,
	output logic [host_bus_pkg::ERROR_COUNT_WIDTH-1:0] write_errors,
	output logic [host_bus_pkg::ERROR_COUNT_WIDTH-1:0] address_errors,
	output logic [waveform_pkg::SAMPLE_WIDTH-1:0] sample,
	output logic sync_out
);

	logic enable_f;
	logic read_f;
	logic select_f;
	logic [host_bus_pkg::BUS_WIDTH-1:0] bus_f;
	logic [waveform_pkg::DATA_WIDTH-1:0] read_word;
	logic [waveform_pkg::DATA_WIDTH-1:0] write_data;
	logic [waveform_pkg::WORD_ADDR_WIDTH-1:0] word_address;
	logic write_strobe;
	logic [waveform_pkg::BYTE_ADDR_WIDTH-1:0] byte_address;

	// ------------------------------------------------
	// host side
	strobe_filter strobe_filter_inst (
		.clock(clock), .reset125(reset125),
		.enable(enable), .read(read), .register_select(register_select), .bus_in(bus_in),
		.enable_f(enable_f), .read_f(read_f), .select_f(select_f), .bus_f(bus_f)
	);

	host_bus_slave host_bus_slave_inst (
		.clock(clock), .reset125(reset125),
		.enable_f(enable_f), .read_f(read_f), .select_f(select_f), .bus_f(bus_f),
		.read_word(read_word), .ack_valid(ack_valid),
		.bus_out(bus_out), .bus_out_enable(bus_out_enable),
		.word_address(word_address), .write_strobe(write_strobe), .write_data(write_data),
		.read_errors(read_errors), .write_errors(write_errors),
		.address_errors(address_errors)
	);

	// ------------------------------------------------
	// storage and playback
	waveform_memory waveform_memory_inst (
		.clock(clock),
		.word_address(word_address), .write_strobe(write_strobe),
		.write_data(write_data), .read_word(read_word),
		.byte_address(byte_address), .sample(sample)
	);

	playback_sequencer playback_sequencer_inst (
		.clock(clock), .reset125(reset125), .sync_in(sync_in),
		.byte_address(byte_address), .sync_out(sync_out)
	);

endmodule

`default_nettype wire

//--- project.f
+incdir+dv
logic/host_bus_pkg.sv
logic/waveform_pkg.sv
logic/strobe_filter.sv
logic/host_bus_slave.sv
logic/waveform_memory.sv
logic/playback_sequencer.sv
logic/waveform_player.sv
dv/waveform_player_tb.sv
